// ==== rtl/hisBuilderFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module hisBuilderFsm (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         binHit,
    input  logic [sifhPkg::binBits-1:0]  binAddr,
    output logic [sifhPkg::binBits-1:0]  rdAddr,
    output logic                         rdEn,
    output logic [sifhPkg::binBits-1:0]  wrAddr,
    output logic                         wrEnRam,
    output logic [sifhPkg::cntWidth-1:0] wrData,
    input  logic [sifhPkg::cntWidth-1:0] rdData,
    output logic                         idle
);
    import sifhPkg::*;

    // stage 1 waits for read data, stage 2 writes, stage 3 is the last write
    logic                s1Valid;
    logic                s2Valid;
    logic                s3Valid;
    logic [binBits-1:0]  s1Addr;
    logic [binBits-1:0]  s2Addr;
    logic [binBits-1:0]  s3Addr;
    logic [cntWidth-1:0] s2Data;
    logic [cntWidth-1:0] s3Data;
    logic [cntWidth-1:0] curCount;
    logic [cntWidth-1:0] nextCount;

    assign rdEn   = binHit; // read issued in the hit cycle
    assign rdAddr = binAddr;

    // RAM data is stale if one of the two older hits hit the same bin
    always_comb begin
        if (s2Valid && s2Addr == s1Addr) begin
            curCount = s2Data; // write in flight this cycle
        end else if (s3Valid && s3Addr == s1Addr) begin
            curCount = s3Data; // written while our read was issued
        end else begin
            curCount = rdData;
        end
    end

    assign nextCount = (curCount == '1) ? curCount : curCount + 1'b1; // saturate

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= binHit;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= binAddr;
        s2Addr <= s1Addr;
        s2Data <= nextCount;
        s3Addr <= s2Addr;
        s3Data <= s2Data;
    end

    assign wrEnRam = s2Valid; // write in the third cycle
    assign wrAddr  = s2Addr;
    assign wrData  = s2Data;

    assign idle = !s1Valid && !s2Valid; // nothing left to write

endmodule

`default_nettype wire

// ==== rtl/histRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module histRam (
    input  logic                         clk,
    input  logic                         we,
    input  logic [sifhPkg::binBits-1:0]  waddr,
    input  logic [sifhPkg::cntWidth-1:0] wdata,
    input  logic                         re,
    input  logic [sifhPkg::binBits-1:0]  raddr,
    output logic [sifhPkg::cntWidth-1:0] rdata
);
    import sifhPkg::*;

    logic [cntWidth-1:0] mem [numBins];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr]; // old data on same-address write
        end
    end

endmodule

`default_nettype wire

// ==== rtl/peakFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

module peakFinder (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         scanStart,
    output logic [sifhPkg::binBits-1:0]  rdAddr,
    output logic                         rdEn,
    input  logic [sifhPkg::cntWidth-1:0] rdData,
    output logic                         scanDone,
    output logic [sifhPkg::binBits-1:0]  maxBin,
    output logic [sifhPkg::cntWidth-1:0] maxCount
);
    import sifhPkg::*;

    logic               active;
    logic [binBits-1:0] rdIdx;
    logic               cmpValid;
    logic [binBits-1:0] cmpAddr;

    assign rdEn   = active;
    assign rdAddr = rdIdx;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active   <= 1'b0;
            rdIdx    <= '0;
            cmpValid <= 1'b0;
            cmpAddr  <= '0;
            scanDone <= 1'b0;
            maxBin   <= '0;
            maxCount <= '0;
        end else begin
            cmpValid <= active; // rdData belongs to cmpAddr
            cmpAddr  <= rdIdx;
            scanDone <= cmpValid && cmpAddr == binBits'(numBins - 1);

            if (scanStart) begin
                active <= 1'b1;
                rdIdx  <= '0;
            end else if (active) begin
                rdIdx <= rdIdx + 1'b1;
                if (rdIdx == binBits'(numBins - 1)) begin
                    active <= 1'b0;
                end
            end

            // bin 0 seeds the search and later bins must be strictly larger
            if (cmpValid && (cmpAddr == '0 || rdData > maxCount)) begin
                maxBin   <= cmpAddr;
                maxCount <= rdData;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sifhPkg.sv ====
`default_nettype none

package sifhPkg;

    // TDC timestamp
    localparam int tsWidth = 12;

    // one histogram address, used for both coarse and fine bins
    localparam int binBits = 4;
    localparam int numBins = 1 << binBits;

    // bin counts saturate at all ones
    localparam int cntWidth = 5;

    // reported peak is window bits followed by fine bits
    localparam int peakWidth = 2 * binBits;

    // accepted hits per build pass
    localparam int hitsPerPass = 32;
    localparam int hitCntWidth = $clog2(hitsPerPass);

endpackage

`default_nettype wire

// ==== rtl/sifhTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          start,
    input  logic                          hit,
    input  logic [sifhPkg::tsWidth-1:0]   data,
    output logic                          wrEn,
    output logic                          busy,
    output logic                          resultValid,
    output logic [sifhPkg::peakWidth-1:0] peakBin,
    output logic [sifhPkg::cntWidth-1:0]  peakCount
);
    import sifhPkg::*;

    typedef enum logic [3:0] {
        stIdle,
        stClearCoarse,
        stBuildCoarse,
        stFindCoarse,
        stSetWindow,
        stClearFine,
        stBuildFine,
        stFindFine,
        stDone
    } seqState;

    seqState state;

    logic [hitCntWidth-1:0] hitCnt;
    logic [binBits-1:0]     clrAddr;
    logic [binBits-1:0]     window;
    logic [binBits-1:0]     coarseBits;
    logic [binBits-1:0]     fineBits;
    logic [binBits-1:0]     binAddr;
    logic                   accept;
    logic                   binHit;
    logic                   clearing;
    logic                   building;
    logic                   finding;
    logic                   scanStart;

    logic [binBits-1:0]  bRdAddr;
    logic                bRdEn;
    logic [binBits-1:0]  bWrAddr;
    logic                bWrEn;
    logic [cntWidth-1:0] bWrData;
    logic                builderIdle;

    logic [binBits-1:0]  fRdAddr;
    logic                fRdEn;
    logic                scanDone;
    logic [binBits-1:0]  maxBin;
    logic [cntWidth-1:0] maxCount;

    logic                ramWe;
    logic [binBits-1:0]  ramWaddr;
    logic [cntWidth-1:0] ramWdata;
    logic                ramRe;
    logic [binBits-1:0]  ramRaddr;
    logic [cntWidth-1:0] ramRdata;

    assign clearing = state == stClearCoarse || state == stClearFine;
    assign building = state == stBuildCoarse || state == stBuildFine;
    assign finding  = state == stFindCoarse || state == stFindFine;

    assign busy        = state != stIdle;
    assign resultValid = state == stDone;

    assign accept     = hit && wrEn; // hits outside wrEn are dropped
    assign coarseBits = data[tsWidth-1 -: binBits];
    assign fineBits   = data[tsWidth-binBits-1 -: binBits];

    // fine pass only counts hits inside the latched coarse window
    assign binHit  = accept && (state == stBuildCoarse ||
                                (state == stBuildFine && coarseBits == window));
    assign binAddr = (state == stBuildFine) ? fineBits : coarseBits;

    assign scanStart = building && !wrEn && builderIdle; // pass drained

    // memory port muxing
    assign ramWe    = clearing ? 1'b1 : bWrEn;
    assign ramWaddr = clearing ? clrAddr : bWrAddr;
    assign ramWdata = clearing ? '0 : bWrData;
    assign ramRe    = finding ? fRdEn : bRdEn;
    assign ramRaddr = finding ? fRdAddr : bRdAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= stIdle;
            wrEn      <= 1'b0;
            hitCnt    <= '0;
            clrAddr   <= '0;
            window    <= '0;
            peakBin   <= '0;
            peakCount <= '0;
        end else begin
            if (accept) begin
                hitCnt <= hitCnt + 1'b1;
                if (hitCnt == hitCntWidth'(hitsPerPass - 1)) begin
                    wrEn <= 1'b0; // quota reached
                end
            end

            case (state)
                stIdle: begin
                    if (start) begin
                        clrAddr <= '0;
                        state   <= stClearCoarse;
                    end
                end
                stClearCoarse, stClearFine: begin
                    clrAddr <= clrAddr + 1'b1; // one zero write per cycle
                    if (clrAddr == binBits'(numBins - 1)) begin
                        wrEn   <= 1'b1;
                        hitCnt <= '0;
                        state  <= (state == stClearCoarse) ? stBuildCoarse : stBuildFine;
                    end
                end
                stBuildCoarse: begin
                    if (scanStart) begin
                        state <= stFindCoarse;
                    end
                end
                stFindCoarse: begin
                    if (scanDone) begin
                        state <= stSetWindow;
                    end
                end
                stSetWindow: begin
                    window  <= maxBin; // busiest coarse bin
                    clrAddr <= '0;
                    state   <= stClearFine;
                end
                stBuildFine: begin
                    if (scanStart) begin
                        state <= stFindFine;
                    end
                end
                stFindFine: begin
                    if (scanDone) begin
                        peakBin   <= {window, maxBin};
                        peakCount <= maxCount;
                        state     <= stDone;
                    end
                end
                stDone: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    histRam i_histRam (
        .clk   (clk),
        .we    (ramWe),
        .waddr (ramWaddr),
        .wdata (ramWdata),
        .re    (ramRe),
        .raddr (ramRaddr),
        .rdata (ramRdata)
    );

    hisBuilderFsm i_hisBuilderFsm (
        .clk     (clk),
        .res     (res),
        .binHit  (binHit),
        .binAddr (binAddr),
        .rdAddr  (bRdAddr),
        .rdEn    (bRdEn),
        .wrAddr  (bWrAddr),
        .wrEnRam (bWrEn),
        .wrData  (bWrData),
        .rdData  (ramRdata),
        .idle    (builderIdle)
    );

    peakFinder i_peakFinder (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .rdAddr    (fRdAddr),
        .rdEn      (fRdEn),
        .rdData    (ramRdata),
        .scanDone  (scanDone),
        .maxBin    (maxBin),
        .maxCount  (maxCount)
    );

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the peak finder testbench with Verilator, then grep the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module sifhTb -Mdir obj_dir -f sources.f \
    && ./obj_dir/VsifhTb > sim.log 2>&1 \
    || { echo "build or simulation run did not complete"; exit 1; }

cat sim.log

grep -q "CHECKS FAILED" sim.log \
    && { echo "result: failing checks found in sim.log"; exit 1; } \
    || { echo "result: no failing checks in sim.log"; exit 0; }

// ==== sources.f ====
rtl/sifhPkg.sv
rtl/histRam.sv
rtl/hisBuilderFsm.sv
rtl/peakFinder.sv
rtl/sifhTop.sv
verification/sifhTb.sv

// ==== verification/sifhTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTb;
    import sifhPkg::*;

    // seven measurements of at most about 350 cycles each at gaps up to 3
    localparam int timeoutCycles = 20000;
    localparam int satCount      = (1 << cntWidth) - 1;

    logic                 clk;
    logic                 res;
    logic                 start;
    logic                 hit;
    logic [tsWidth-1:0]   data;
    logic                 wrEn;
    logic                 busy;
    logic                 resultValid;
    logic [peakWidth-1:0] peakBin;
    logic [cntWidth-1:0]  peakCount;

    logic [tsWidth-1:0] passTs [2][hitsPerPass]; // pass 0 coarse, pass 1 fine
    logic [tsWidth-1:0] junkTs;
    int                 hist [numBins];
    int                 errors = 0;
    int                 tests  = 0;
    int                 cycles = 0;

    sifhTop i_sifhTop (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .hit         (hit),
        .data        (data),
        .wrEn        (wrEn),
        .busy        (busy),
        .resultValid (resultValid),
        .peakBin     (peakBin),
        .peakCount   (peakCount)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1; // drive just after the edge
    endtask

    // reference histogram, coarse pass or window-filtered fine pass
    function automatic void buildHist(input int pass, input logic [binBits-1:0] win);
        logic [binBits-1:0] coarse;
        logic [binBits-1:0] fine;
        for (int b = 0; b < numBins; b++) hist[b] = 0;
        for (int i = 0; i < hitsPerPass; i++) begin
            coarse = passTs[pass][i][tsWidth-1 -: binBits];
            fine   = passTs[pass][i][tsWidth-binBits-1 -: binBits];
            if (pass == 0) begin
                if (hist[coarse] < satCount) hist[coarse]++;
            end else if (coarse == win && hist[fine] < satCount) begin
                hist[fine]++;
            end
        end
    endfunction

    // lowest index wins on equal counts
    function automatic logic [binBits-1:0] bestBin();
        int best;
        best = 0;
        for (int b = 1; b < numBins; b++) if (hist[b] > hist[best]) best = b;
        return binBits'(best);
    endfunction

    task automatic reportTest(input string name, input int errBefore);
        tests++;
        if (errors == errBefore) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errBefore);
    endtask

    task automatic feedPass(input int pass, input int maxGap, input bit junk);
        int gap;
        for (int i = 0; i < hitsPerPass; i++) begin
            gap = (maxGap > 0) ? int'($urandom_range(maxGap, 0)) : 0;
            hit = 1'b0;
            repeat (gap) nextCycle();
            while (!wrEn) begin
                hit  = junk; // must be dropped by the DUT
                data = junkTs;
                nextCycle();
            end
            hit  = 1'b1;
            data = passTs[pass][i];
            nextCycle();
        end
        hit = 1'b0;
    endtask

    task automatic runMeasurement(input string name, input int maxGap, input bit junk);
        logic [binBits-1:0]   window;
        logic [binBits-1:0]   fineBin;
        logic [peakWidth-1:0] expBin;
        logic [cntWidth-1:0]  expCount;
        int                   errBefore;
        errBefore = errors;
        buildHist(0, '0);
        window = bestBin();
        buildHist(1, window);
        fineBin  = bestBin();
        expBin   = {window, fineBin};
        expCount = cntWidth'(hist[fineBin]);
        start = 1'b1;
        nextCycle();
        start = 1'b0;
        feedPass(0, maxGap, junk);
        feedPass(1, maxGap, junk);
        while (!resultValid) begin
            hit  = junk; // pass over and wrEn low
            data = junkTs;
            nextCycle();
        end
        hit = 1'b0;
        if (peakBin !== expBin) begin
            $display("CHECK FAILED at %0t: %s peakBin %h, expected %h",
                     $time, name, peakBin, expBin);
            errors++;
        end
        if (peakCount !== expCount) begin
            $display("CHECK FAILED at %0t: %s peakCount %0d, expected %0d",
                     $time, name, peakCount, expCount);
            errors++;
        end
        if (busy !== 1'b1) begin
            $display("CHECK FAILED at %0t: %s busy %b with the result, expected 1",
                     $time, name, busy);
            errors++;
        end
        nextCycle(); // back to idle
        if (resultValid !== 1'b0 || busy !== 1'b0) begin
            $display("CHECK FAILED at %0t: %s resultValid %b busy %b after the result, expected 0 0",
                     $time, name, resultValid, busy);
            errors++;
        end
        reportTest(name, errBefore);
    endtask

    task automatic testReset();
        int errBefore;
        bit moved;
        errBefore = errors;
        moved     = 1'b0;
        if (wrEn !== 1'b0 || busy !== 1'b0 || resultValid !== 1'b0) begin
            $display("CHECK FAILED at %0t: outputs after reset wrEn %b busy %b resultValid %b",
                     $time, wrEn, busy, resultValid);
            errors++;
        end
        hit  = 1'b1;
        data = 12'h5a5;
        nextCycle();
        hit = 1'b0;
        repeat (2 * numBins) begin
            if (busy !== 1'b0 || wrEn !== 1'b0 || resultValid !== 1'b0) moved = 1'b1;
            nextCycle();
        end
        if (moved) begin
            $display("CHECK FAILED at %0t: a hit without start woke up the sequencer", $time);
            errors++;
        end
        reportTest("reset", errBefore);
    endtask

    task automatic testBackToBack();
        for (int i = 0; i < hitsPerPass; i++) begin
            passTs[0][i] = 12'h3c7;
            passTs[1][i] = 12'h3c7;
        end
        runMeasurement("back to back", 0, 1'b0); // forwarding and saturation
    endtask

    task automatic testTieBreak();
        for (int i = 0; i < hitsPerPass; i++) begin
            passTs[0][i] = i[0] ? 12'h520 : 12'h940; // 16 each with the upper bin first
            if (i < 10) passTs[1][i] = 12'h5c0;
            else if (i < 20) passTs[1][i] = 12'h530;
            else passTs[1][i] = 12'h970;
        end
        runMeasurement("tie break", 1, 1'b0);
    endtask

    task automatic testWindow();
        for (int i = 0; i < hitsPerPass; i++) begin
            passTs[0][i] = (i % 3 == 0) ? {4'ha, 8'($urandom)} : tsWidth'($urandom);
            passTs[1][i] = (i % 2 == 0) ? {4'ha, 8'($urandom)} : tsWidth'($urandom);
        end
        runMeasurement("window filter", 2, 1'b0);
    endtask

    task automatic testIgnoreLow();
        for (int i = 0; i < hitsPerPass; i++) begin
            passTs[0][i] = (i < 20) ? 12'h6f0 : 12'h1f0;
            passTs[1][i] = (i < 20) ? {8'h6b, 4'($urandom)} : 12'h620;
        end
        junkTs = 12'h6b0; // would raise the peak if it leaked in
        runMeasurement("hits while wrEn low", 1, 1'b1);
    endtask

    task automatic testRandom();
        logic [binBits-1:0] window;
        for (int m = 0; m < 3; m++) begin
            for (int i = 0; i < hitsPerPass; i++) passTs[0][i] = tsWidth'($urandom);
            buildHist(0, '0);
            window = bestBin();
            for (int i = 0; i < hitsPerPass; i++) begin
                passTs[1][i] = i[0] ? {window, 8'($urandom)} : tsWidth'($urandom);
            end
            runMeasurement($sformatf("random %0d", m), 3, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'hacd2));
        clk    = 1'b0;
        res    = 1'b0;
        start  = 1'b0;
        hit    = 1'b0;
        data   = '0;
        junkTs = '0;
        repeat (4) @(posedge clk);
        #1;
        res = 1'b1;
        testReset();
        testBackToBack();
        testTieBreak();
        testWindow();
        testIgnoreLow();
        testRandom();
        $display("summary: %0d tests, %0d errors, %0d cycles", tests, errors, cycles);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
